/* verilog.f */
source/mempool_system_pkg.sv
source/port_arbiter.sv
source/target_router.sv
source/l2_sram.sv
source/bootrom.sv
source/ctrl_registers.sv
source/mempool_system.sv
verif/mempool_system_props.sv
verif/tb_mempool_system.sv

/* Makefile */
TOP := tb_mempool_system

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* verif/tb_mempool_system.sv */
`timescale 1ns/1ps

module tb_mempool_system;

  import mempool_system_pkg::*;

  localparam int unsigned RunCycles = 4000;
  localparam int unsigned StressEnd = 600; // Every port requests back to back
  localparam int unsigned WaitLimit = 100;

  typedef struct {
    port_idx_t   port;
    data_t       data;
    logic        check;    // Read with a known word
    logic        internal;
    int unsigned cyc;      // Grant cycle
  } rsp_t;

  logic                 clk_i;
  logic                 rst_n_i;
  logic [NumPorts-1:0]  port_req_i;
  addr_t [NumPorts-1:0] port_addr_i;
  logic [NumPorts-1:0]  port_we_i;
  data_t [NumPorts-1:0] port_wdata_i;
  strb_t [NumPorts-1:0] port_be_i;
  logic [NumPorts-1:0]  port_gnt_o;
  logic [NumPorts-1:0]  port_rvalid_o;
  data_t [NumPorts-1:0] port_rdata_o;
  logic                 ext_req_o;
  addr_t                ext_addr_o;
  logic                 ext_we_o;
  data_t                ext_wdata_o;
  strb_t                ext_be_o;
  logic                 ext_gnt_i;
  logic                 ext_rvalid_i;
  data_t                ext_rdata_i;
  core_mask_t           wake_up_o;
  logic                 eoc_valid_o;
  logic                 busy_o;

  logic [31:0]         rng_state;
  data_t               l2_model [int unsigned];
  data_t               ext_store [addr_t]; // Responder memory
  core_mask_t          wake_model;
  core_mask_t          wake_exp;
  data_t               eoc_model;
  rsp_t                exp_q [$];
  logic                ext_open;
  logic                ext_req_exp; // High from the cycle after the grant until ext_gnt_i
  addr_t               ext_addr_exp;
  logic                ext_we_exp;
  data_t               ext_wdata_exp;
  strb_t               ext_be_exp;
  int unsigned         ext_phase;
  int unsigned         ext_wait;
  int unsigned         cyc;
  int unsigned         drain;
  int unsigned         pass_cnt [NumPorts];
  int unsigned         wait_cnt [NumPorts];
  logic [NumPorts-1:0] granted;

  mempool_system dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t be);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic addr_t random_addr(logic [31:0] r);
    case (r[30:28])
      3'd3:       return BootromBaseAddr + (r & 32'h0000_FFFC);
      3'd4, 3'd5: return CtrlBaseAddr + (r & 32'h0000_001C); // Includes unmapped offsets
      3'd6:       return (r[27] ? 32'h1000_0000 : 32'hC000_0000) + (r & 32'h0000_001C);
      default:    return L2BaseAddr + (r & 32'h0018_003C);    // Aliases above bit 13
    endcase
  endfunction

  function automatic target_e decode_target(addr_t a);
    if (a >= CtrlBaseAddr && a <= CtrlEndAddr)
      return TgtCtrl;
    if (a >= L2BaseAddr && a <= L2EndAddr)
      return TgtL2;
    if (a >= BootromBaseAddr && a <= BootromEndAddr)
      return TgtBootrom;
    return TgtExternal;
  endfunction

  function automatic data_t ctrl_value(addr_t a);
    case (a[15:0])
      CtrlWakeUpOff:    return data_t'(wake_model);
      CtrlEocOff:       return eoc_model;
      CtrlTcdmStartOff: return TCDMBaseAddr;
      CtrlTcdmEndOff:   return TCDMBaseAddr + TCDMSize;
      CtrlNumCoresOff:  return data_t'(NumCores);
      default:          return '0;
    endcase
  endfunction

  function automatic data_t ext_value(addr_t a);
    return ext_store.exists(a) ? ext_store[a] : ~a;
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_data(string name, data_t act, data_t exp);
    if (act !== exp)
      report_failure($sformatf("CHECK FAILED %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic compare_addr(string name, addr_t act, addr_t exp);
    if (act !== exp)
      report_failure($sformatf("CHECK FAILED %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic compare_strb(string name, strb_t act, strb_t exp);
    if (act !== exp)
      report_failure($sformatf("CHECK FAILED %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic compare_mask(string name, core_mask_t act, core_mask_t exp);
    if (act !== exp)
      report_failure($sformatf("CHECK FAILED %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic compare_bit(string name, logic act, logic exp);
    if (act !== exp)
      report_failure($sformatf("CHECK FAILED %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic check_idle();
    compare_bit("port_gnt_o", |port_gnt_o, 1'b0);
    compare_bit("port_rvalid_o", |port_rvalid_o, 1'b0);
    compare_bit("ext_req_o", ext_req_o, 1'b0);
    compare_mask("wake_up_o", wake_up_o, '0);
    compare_bit("eoc_valid_o", eoc_valid_o, 1'b0);
    compare_bit("busy_o", busy_o, 1'b0);
  endtask

  // Apply one granted request to the model and queue its response
  task automatic model_grant(int unsigned p);
    rsp_t        rsp;
    addr_t       a;
    int unsigned idx;
    a            = port_addr_i[p];
    idx          = {20'd0, a[13:2]};
    rsp.port     = port_idx_t'(p);
    rsp.data     = '0;
    rsp.check    = !port_we_i[p];
    rsp.internal = 1'b1;
    rsp.cyc      = cyc;
    case (decode_target(a))
      TgtL2: begin
        if (port_we_i[p] && l2_model.exists(idx))
          l2_model[idx] = merge_bytes(l2_model[idx], port_wdata_i[p], port_be_i[p]);
        else if (port_we_i[p] && port_be_i[p] == 4'hF)
          l2_model[idx] = port_wdata_i[p];
        else if (!port_we_i[p] && l2_model.exists(idx))
          rsp.data = l2_model[idx];
        else
          rsp.check = 1'b0; // Never fully written
      end
      TgtBootrom: rsp.data = BootromImage[a[4:2]];
      TgtCtrl: begin
        rsp.data = ctrl_value(a);
        if (port_we_i[p] && a[15:0] == CtrlWakeUpOff) begin
          wake_model = port_wdata_i[p][NumCores-1:0];
          wake_exp   = wake_model;
        end
        if (port_we_i[p] && a[15:0] == CtrlEocOff)
          eoc_model = merge_bytes(eoc_model, port_wdata_i[p], port_be_i[p]);
      end
      default: begin
        rsp.internal  = 1'b0;
        rsp.data      = ext_value(a);
        ext_open      = 1'b1;
        ext_req_exp   = 1'b1;
        ext_addr_exp  = a;
        ext_we_exp    = port_we_i[p];
        ext_wdata_exp = port_wdata_i[p];
        ext_be_exp    = port_be_i[p];
      end
    endcase
    exp_q.push_back(rsp);
  endtask

  // Rising edge: new requests and the external responder
  task automatic drive_step(logic issue);
    logic [31:0] r;
    logic [31:0] r2;
    for (int unsigned p = 0; p < NumPorts; p++) begin
      if (!port_req_i[p] || granted[p]) begin
        r  = next_rand();
        r2 = next_rand();
        port_req_i[p]   <= issue && (cyc < StressEnd || r2[7:6] != 2'b00);
        port_addr_i[p]  <= random_addr(r);
        port_we_i[p]    <= r2[0];
        port_be_i[p]    <= r2[1] ? 4'hF : r2[5:2];
        port_wdata_i[p] <= next_rand();
      end
    end
    case (ext_phase)
      1: begin
        if (ext_wait == 0) begin
          ext_gnt_i <= 1'b1;
          ext_wait  = next_rand() % 4;
          ext_phase = 2;
        end else
          ext_wait--;
      end
      2: begin
        ext_gnt_i <= 1'b0;
        if (ext_wait == 0) begin
          ext_rvalid_i <= 1'b1;
          ext_rdata_i  <= ext_value(ext_addr_o);
          if (ext_we_o)
            ext_store[ext_addr_o] = merge_bytes(ext_value(ext_addr_o), ext_wdata_o, ext_be_o);
          ext_phase = 3;
        end else
          ext_wait--;
      end
      3: begin
        ext_rvalid_i <= 1'b0;
        ext_phase = 0;
      end
      default: ;
    endcase
  endtask

  // Falling edge: outputs are settled here
  task automatic sample_step();
    rsp_t rsp;
    cyc++;
    compare_bit("busy_o", busy_o, (|port_req_i) | ext_open);
    compare_mask("wake_up_o", wake_up_o, wake_exp);
    compare_bit("eoc_valid_o", eoc_valid_o, eoc_model[0]);
    compare_bit("ext_req_o", ext_req_o, ext_req_exp);
    if (ext_gnt_i)
      ext_req_exp = 1'b0;
    if (ext_open && port_gnt_o != '0)
      report_failure("A port was granted while an external request was outstanding");
    for (int unsigned p = 0; p < NumPorts; p++) begin
      if (port_rvalid_o[p]) begin
        if (exp_q.size() == 0)
          report_failure($sformatf("Port %0d gave rvalid without a granted request", p));
        rsp = exp_q.pop_front();
        if (rsp.port != port_idx_t'(p))
          report_failure($sformatf("Response on port %0d, expected port %0d", p, rsp.port));
        if (rsp.internal && cyc != rsp.cyc + 1)
          report_failure("Internal response did not come one cycle after its grant");
        if (rsp.check)
          compare_data($sformatf("port_rdata_o[%0d]", p), port_rdata_o[p], rsp.data);
        if (!rsp.internal)
          ext_open = 1'b0;
      end
    end
    if (exp_q.size() != 0 && exp_q[0].internal && cyc > exp_q[0].cyc + 1)
      report_failure("No rvalid one cycle after an internal grant");
    if (exp_q.size() != 0 && cyc > exp_q[0].cyc + WaitLimit)
      report_failure("Timed out waiting for an external response");
    if (ext_phase == 0 && ext_req_o) begin
      compare_addr("ext_addr_o", ext_addr_o, ext_addr_exp);
      compare_bit("ext_we_o", ext_we_o, ext_we_exp);
      compare_data("ext_wdata_o", ext_wdata_o, ext_wdata_exp);
      compare_strb("ext_be_o", ext_be_o, ext_be_exp);
      ext_wait  = next_rand() % 4;
      ext_phase = 1;
    end
    wake_exp = '0;
    for (int unsigned p = 0; p < NumPorts; p++) begin
      if (port_gnt_o[p]) begin
        if (!port_req_i[p])
          report_failure($sformatf("Port %0d was granted without a request", p));
        model_grant(p);
        pass_cnt[p] = 0;
        wait_cnt[p] = 0;
      end else if (port_req_i[p]) begin
        wait_cnt[p]++;
        if (port_gnt_o != '0)
          pass_cnt[p]++;
        if (pass_cnt[p] >= NumPorts)
          report_failure($sformatf("Port %0d passed over by %0d grants", p, pass_cnt[p]));
        if (wait_cnt[p] > WaitLimit)
          report_failure($sformatf("Port %0d timed out waiting for a grant", p));
      end else begin
        pass_cnt[p] = 0;
        wait_cnt[p] = 0;
      end
    end
    granted = port_gnt_o;
  endtask

  initial begin
    rng_state   = 32'd33;
    cyc         = 0;
    ext_phase   = 0;
    ext_wait    = 0;
    ext_open    = 1'b0;
    ext_req_exp = 1'b0;
    wake_model  = '0;
    wake_exp    = '0;
    eoc_model   = '0;
    granted     = '0;
    pass_cnt    = '{default: 0};
    wait_cnt    = '{default: 0};
    rst_n_i      <= 1'b0;
    port_req_i   <= '0;
    port_addr_i  <= '0;
    port_we_i    <= '0;
    port_wdata_i <= '0;
    port_be_i    <= '0;
    ext_gnt_i    <= 1'b0;
    ext_rvalid_i <= 1'b0;
    ext_rdata_i  <= '0;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < 2; i++) begin
      @(negedge clk_i);
      check_idle();
    end
    for (int unsigned i = 0; i < RunCycles; i++) begin
      @(posedge clk_i);
      drive_step(1'b1);
      @(negedge clk_i);
      sample_step();
    end
    drain = 0;
    while ((port_req_i != '0 || exp_q.size() != 0) && drain < WaitLimit) begin
      @(posedge clk_i);
      drive_step(1'b0);
      @(negedge clk_i);
      sample_step();
      drain++;
    end
    if (port_req_i != '0 || exp_q.size() != 0) begin
      report_failure("Requests still pending after the drain timeout");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule : tb_mempool_system

/* verif/mempool_system_props.sv */
`timescale 1ns/1ps

module mempool_system_props (
  input logic                                    clk_i,
  input logic                                    rst_n_i,
  input logic [mempool_system_pkg::NumPorts-1:0] port_gnt_i,
  input logic [mempool_system_pkg::NumPorts-1:0] port_rvalid_i,
  input logic                                    ext_gnt_i,
  input logic                                    ext_rvalid_i,
  input mempool_system_pkg::core_mask_t          wake_up_i,
  input logic                                    ctrl_req_i,
  input logic                                    mem_we_i,
  input mempool_system_pkg::addr_t               mem_addr_i
);

  import mempool_system_pkg::*;

  logic ext_open_q; // External grant seen, response pending

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      ext_open_q <= 1'b0;
    else if (ext_gnt_i)
      ext_open_q <= 1'b1;
    else if (ext_rvalid_i)
      ext_open_q <= 1'b0;
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(port_gnt_i))
    else $error("more than one port granted in a cycle");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(port_rvalid_i))
    else $error("more than one port answered in a cycle");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ext_gnt_i || ext_open_q) |-> (port_gnt_i == '0))
    else $error("port granted while an external request is outstanding");

  // A pulse needs a wake-up write in the cycle before
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wake_up_i != '0) |-> $past(ctrl_req_i && mem_we_i && mem_addr_i[15:0] == CtrlWakeUpOff))
    else $error("wake-up pulse without a preceding wake-up write");

endmodule : mempool_system_props

bind mempool_system mempool_system_props props0 (
  .clk_i        (clk_i        ),
  .rst_n_i      (rst_n_i      ),
  .port_gnt_i   (port_gnt_o   ),
  .port_rvalid_i(port_rvalid_o),
  .ext_gnt_i    (ext_gnt_i    ),
  .ext_rvalid_i (ext_rvalid_i ),
  .wake_up_i    (wake_up_o    ),
  .ctrl_req_i   (ctrl_req     ),
  .mem_we_i     (mem_we       ),
  .mem_addr_i   (mem_addr     )
);

/* source/mempool_system.sv */
`timescale 1ns/1ps

module mempool_system (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  logic [mempool_system_pkg::NumPorts-1:0]                       port_req_i,
  input  mempool_system_pkg::addr_t [mempool_system_pkg::NumPorts-1:0] port_addr_i,
  input  logic [mempool_system_pkg::NumPorts-1:0]                       port_we_i,
  input  mempool_system_pkg::data_t [mempool_system_pkg::NumPorts-1:0] port_wdata_i,
  input  mempool_system_pkg::strb_t [mempool_system_pkg::NumPorts-1:0] port_be_i,
  output logic [mempool_system_pkg::NumPorts-1:0]                       port_gnt_o,
  output logic [mempool_system_pkg::NumPorts-1:0]                       port_rvalid_o,
  output mempool_system_pkg::data_t [mempool_system_pkg::NumPorts-1:0] port_rdata_o,
  output logic                                                          ext_req_o,
  output mempool_system_pkg::addr_t                                     ext_addr_o,
  output logic                                                          ext_we_o,
  output mempool_system_pkg::data_t                                     ext_wdata_o,
  output mempool_system_pkg::strb_t                                     ext_be_o,
  input  logic                                                          ext_gnt_i,
  input  logic                                                          ext_rvalid_i,
  input  mempool_system_pkg::data_t                                     ext_rdata_i,
  output mempool_system_pkg::core_mask_t                                wake_up_o,
  output logic                                                          eoc_valid_o,
  output logic                                                          busy_o
);

  import mempool_system_pkg::*;

  // Arbiter to router
  logic      accept;
  logic      sel_valid;
  port_idx_t sel_port;
  addr_t     sel_addr;
  logic      sel_we;
  data_t     sel_wdata;
  strb_t     sel_be;

  // Shared target fields
  addr_t mem_addr;
  logic  mem_we;
  data_t mem_wdata;
  strb_t mem_be;
  logic  l2_req, rom_req, ctrl_req;
  data_t l2_rdata, rom_rdata, ctrl_rdata;

  port_arbiter i_port_arbiter (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .port_req_i  (port_req_i  ),
    .port_addr_i (port_addr_i ),
    .port_we_i   (port_we_i   ),
    .port_wdata_i(port_wdata_i),
    .port_be_i   (port_be_i   ),
    .port_gnt_o  (port_gnt_o  ),
    .accept_i    (accept      ),
    .sel_valid_o (sel_valid   ),
    .sel_port_o  (sel_port    ),
    .sel_addr_o  (sel_addr    ),
    .sel_we_o    (sel_we      ),
    .sel_wdata_o (sel_wdata   ),
    .sel_be_o    (sel_be      )
  );

  target_router i_target_router (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .sel_valid_i  (sel_valid    ),
    .sel_port_i   (sel_port     ),
    .sel_addr_i   (sel_addr     ),
    .sel_we_i     (sel_we       ),
    .sel_wdata_i  (sel_wdata    ),
    .sel_be_i     (sel_be       ),
    .accept_o     (accept       ),
    .mem_addr_o   (mem_addr     ),
    .mem_we_o     (mem_we       ),
    .mem_wdata_o  (mem_wdata    ),
    .mem_be_o     (mem_be       ),
    .l2_req_o     (l2_req       ),
    .rom_req_o    (rom_req      ),
    .ctrl_req_o   (ctrl_req     ),
    .l2_rdata_i   (l2_rdata     ),
    .rom_rdata_i  (rom_rdata    ),
    .ctrl_rdata_i (ctrl_rdata   ),
    .ext_req_o    (ext_req_o    ),
    .ext_addr_o   (ext_addr_o   ),
    .ext_we_o     (ext_we_o     ),
    .ext_wdata_o  (ext_wdata_o  ),
    .ext_be_o     (ext_be_o     ),
    .ext_gnt_i    (ext_gnt_i    ),
    .ext_rvalid_i (ext_rvalid_i ),
    .ext_rdata_i  (ext_rdata_i  ),
    .port_rvalid_o(port_rvalid_o),
    .port_rdata_o (port_rdata_o ),
    .busy_o       (busy_o       )
  );

  l2_sram i_l2_sram (
    .clk_i  (clk_i    ),
    .req_i  (l2_req   ),
    .we_i   (mem_we   ),
    .addr_i (mem_addr ),
    .wdata_i(mem_wdata),
    .be_i   (mem_be   ),
    .rdata_o(l2_rdata )
  );

  // Writes to the ROM are still answered by the router
  bootrom i_bootrom (
    .clk_i  (clk_i    ),
    .req_i  (rom_req  ),
    .addr_i (mem_addr ),
    .rdata_o(rom_rdata)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (ctrl_req   ),
    .we_i       (mem_we     ),
    .addr_i     (mem_addr   ),
    .wdata_i    (mem_wdata  ),
    .be_i       (mem_be     ),
    .rdata_o    (ctrl_rdata ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

endmodule : mempool_system

/* source/ctrl_registers.sv */
`timescale 1ns/1ps

module ctrl_registers (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  mempool_system_pkg::addr_t      addr_i,
  input  mempool_system_pkg::data_t      wdata_i,
  input  mempool_system_pkg::strb_t      be_i,
  output mempool_system_pkg::data_t      rdata_o,
  output mempool_system_pkg::core_mask_t wake_up_o,
  output logic                           eoc_valid_o
);

  import mempool_system_pkg::*;

  ctrl_off_t  reg_off;
  logic       wr_en;
  core_mask_t wake_up_q;
  core_mask_t wake_pulse_q;
  data_t      eoc_q;
  data_t      rd_value;

  assign reg_off = addr_i[15:0];
  assign wr_en   = req_i & we_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wake_up_q    <= '0;
      wake_pulse_q <= '0;
      eoc_q        <= '0;
    end else begin
      wake_pulse_q <= '0; // One-cycle pulse
      if (wr_en && reg_off == CtrlWakeUpOff) begin
        wake_up_q    <= wdata_i[NumCores-1:0];
        wake_pulse_q <= wdata_i[NumCores-1:0];
      end
      if (wr_en && reg_off == CtrlEocOff) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (be_i[b])
            eoc_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    case (reg_off)
      CtrlWakeUpOff:    rd_value = data_t'(wake_up_q);
      CtrlEocOff:       rd_value = eoc_q;
      CtrlTcdmStartOff: rd_value = TCDMBaseAddr;
      CtrlTcdmEndOff:   rd_value = TCDMBaseAddr + TCDMSize;
      CtrlNumCoresOff:  rd_value = data_t'(NumCores);
      default:          rd_value = '0; // Unmapped
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i)
      rdata_o <= rd_value;
  end

  assign wake_up_o   = wake_pulse_q;
  assign eoc_valid_o = eoc_q[0];

endmodule : ctrl_registers

/* source/bootrom.sv */
`timescale 1ns/1ps

module bootrom (
  input  logic                      clk_i,
  input  logic                      req_i,
  input  mempool_system_pkg::addr_t addr_i,
  output mempool_system_pkg::data_t rdata_o
);

  import mempool_system_pkg::*;

  localparam int unsigned IdxWidth = $clog2(BootromWords);

  logic [IdxWidth-1:0] rom_idx;

  // Image repeats across the window
  assign rom_idx = addr_i[IdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i)
      rdata_o <= BootromImage[rom_idx];
  end

endmodule : bootrom

/* source/l2_sram.sv */
`timescale 1ns/1ps

module l2_sram (
  input  logic                      clk_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  mempool_system_pkg::addr_t addr_i,
  input  mempool_system_pkg::data_t wdata_i,
  input  mempool_system_pkg::strb_t be_i,
  output mempool_system_pkg::data_t rdata_o
);

  import mempool_system_pkg::*;

  data_t                  mem [2**L2AddrWidth];
  logic [L2AddrWidth-1:0] word_idx;

  assign word_idx = addr_i[L2AddrWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (be_i[b])
            mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_o <= mem[word_idx]; // Old word on a write
    end
  end

endmodule : l2_sram

/* source/target_router.sv */
`timescale 1ns/1ps

module target_router (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  logic                                                          sel_valid_i,
  input  mempool_system_pkg::port_idx_t                                 sel_port_i,
  input  mempool_system_pkg::addr_t                                     sel_addr_i,
  input  logic                                                          sel_we_i,
  input  mempool_system_pkg::data_t                                     sel_wdata_i,
  input  mempool_system_pkg::strb_t                                     sel_be_i,
  output logic                                                          accept_o,
  output mempool_system_pkg::addr_t                                     mem_addr_o,
  output logic                                                          mem_we_o,
  output mempool_system_pkg::data_t                                     mem_wdata_o,
  output mempool_system_pkg::strb_t                                     mem_be_o,
  output logic                                                          l2_req_o,
  output logic                                                          rom_req_o,
  output logic                                                          ctrl_req_o,
  input  mempool_system_pkg::data_t                                     l2_rdata_i,
  input  mempool_system_pkg::data_t                                     rom_rdata_i,
  input  mempool_system_pkg::data_t                                     ctrl_rdata_i,
  output logic                                                          ext_req_o,
  output mempool_system_pkg::addr_t                                     ext_addr_o,
  output logic                                                          ext_we_o,
  output mempool_system_pkg::data_t                                     ext_wdata_o,
  output mempool_system_pkg::strb_t                                     ext_be_o,
  input  logic                                                          ext_gnt_i,
  input  logic                                                          ext_rvalid_i,
  input  mempool_system_pkg::data_t                                     ext_rdata_i,
  output logic [mempool_system_pkg::NumPorts-1:0]                       port_rvalid_o,
  output mempool_system_pkg::data_t [mempool_system_pkg::NumPorts-1:0] port_rdata_o,
  output logic                                                          busy_o
);

  import mempool_system_pkg::*;

  target_e   sel_tgt;
  logic      grant;
  logic      rsp_valid_q;
  port_idx_t rsp_port_q;
  target_e   rsp_tgt_q;
  logic      ext_req_q, ext_busy_q;
  port_idx_t ext_port_q;
  logic      ext_done;
  data_t     rsp_rdata;

  always_comb begin
    if (sel_addr_i >= CtrlBaseAddr && sel_addr_i <= CtrlEndAddr)
      sel_tgt = TgtCtrl;
    else if (sel_addr_i >= L2BaseAddr && sel_addr_i <= L2EndAddr)
      sel_tgt = TgtL2;
    else if (sel_addr_i >= BootromBaseAddr && sel_addr_i <= BootromEndAddr)
      sel_tgt = TgtBootrom;
    else
      sel_tgt = TgtExternal;
  end

  // Stall everything while an external access is open
  assign accept_o = ~ext_busy_q;
  assign grant    = sel_valid_i & accept_o;
  assign ext_done = ext_busy_q & ext_rvalid_i;

  assign mem_addr_o  = sel_addr_i;
  assign mem_we_o    = sel_we_i;
  assign mem_wdata_o = sel_wdata_i;
  assign mem_be_o    = sel_be_i;
  assign l2_req_o    = grant && (sel_tgt == TgtL2);
  assign rom_req_o   = grant && (sel_tgt == TgtBootrom);
  assign ctrl_req_o  = grant && (sel_tgt == TgtCtrl);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_port_q  <= '0;
      rsp_tgt_q   <= TgtCtrl;
      ext_req_q   <= 1'b0;
      ext_busy_q  <= 1'b0;
      ext_port_q  <= '0;
    end else begin
      rsp_valid_q <= grant && (sel_tgt != TgtExternal);
      rsp_port_q  <= sel_port_i;
      rsp_tgt_q   <= sel_tgt;
      if (grant && sel_tgt == TgtExternal) begin
        ext_req_q  <= 1'b1;
        ext_busy_q <= 1'b1;
        ext_port_q <= sel_port_i;
      end else begin
        if (ext_req_q && ext_gnt_i)
          ext_req_q <= 1'b0;
        if (ext_done)
          ext_busy_q <= 1'b0;
      end
    end
  end

  // External request fields
  always_ff @(posedge clk_i) begin
    if (grant && sel_tgt == TgtExternal) begin
      ext_addr_o  <= sel_addr_i;
      ext_we_o    <= sel_we_i;
      ext_wdata_o <= sel_wdata_i;
      ext_be_o    <= sel_be_i;
    end
  end

  assign ext_req_o = ext_req_q;

  always_comb begin
    if (ext_done)
      rsp_rdata = ext_rdata_i;
    else begin
      case (rsp_tgt_q)
        TgtCtrl:    rsp_rdata = ctrl_rdata_i;
        TgtL2:      rsp_rdata = l2_rdata_i;
        TgtBootrom: rsp_rdata = rom_rdata_i;
        default:    rsp_rdata = '0;
      endcase
    end
  end

  always_comb begin
    port_rvalid_o = '0;
    if (rsp_valid_q)
      port_rvalid_o[rsp_port_q] = 1'b1;
    if (ext_done)
      port_rvalid_o[ext_port_q] = 1'b1;
  end

  assign port_rdata_o = {NumPorts{rsp_rdata}}; // Same word on all ports, rvalid picks one
  assign busy_o       = sel_valid_i | ext_busy_q;

endmodule : target_router

/* source/port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  logic [mempool_system_pkg::NumPorts-1:0]                       port_req_i,
  input  mempool_system_pkg::addr_t [mempool_system_pkg::NumPorts-1:0] port_addr_i,
  input  logic [mempool_system_pkg::NumPorts-1:0]                       port_we_i,
  input  mempool_system_pkg::data_t [mempool_system_pkg::NumPorts-1:0] port_wdata_i,
  input  mempool_system_pkg::strb_t [mempool_system_pkg::NumPorts-1:0] port_be_i,
  output logic [mempool_system_pkg::NumPorts-1:0]                       port_gnt_o,
  input  logic                                                          accept_i,
  output logic                                                          sel_valid_o,
  output mempool_system_pkg::port_idx_t                                 sel_port_o,
  output mempool_system_pkg::addr_t                                     sel_addr_o,
  output logic                                                          sel_we_o,
  output mempool_system_pkg::data_t                                     sel_wdata_o,
  output mempool_system_pkg::strb_t                                     sel_be_o
);

  import mempool_system_pkg::*;

  port_idx_t rr_ptr_q;
  port_idx_t sel_idx;
  logic      found;
  logic      grant;

  // First requester at or after the pointer
  always_comb begin
    int unsigned cand;
    found   = 1'b0;
    sel_idx = rr_ptr_q;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = int'(rr_ptr_q) + i;
      if (cand >= NumPorts)
        cand = cand - NumPorts; // wrap
      if (!found && port_req_i[cand]) begin
        found   = 1'b1;
        sel_idx = port_idx_t'(cand);
      end
    end
  end

  assign grant = found & accept_i;

  assign sel_valid_o = found;
  assign sel_port_o  = sel_idx;
  assign sel_addr_o  = port_addr_i[sel_idx];
  assign sel_we_o    = port_we_i[sel_idx];
  assign sel_wdata_o = port_wdata_i[sel_idx];
  assign sel_be_o    = port_be_i[sel_idx];

  always_comb begin
    port_gnt_o = '0;
    if (grant)
      port_gnt_o[sel_idx] = 1'b1;
  end

  // Pointer moves one past the winner
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (grant) begin
      if (sel_idx == port_idx_t'(NumPorts - 1))
        rr_ptr_q <= '0;
      else
        rr_ptr_q <= sel_idx + port_idx_t'(1);
    end
  end

endmodule : port_arbiter

/* source/mempool_system_pkg.sv */
package mempool_system_pkg;

  // Sizes
  localparam int unsigned NumPorts    = 3;
  localparam int unsigned NumCores    = 4;
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned L2AddrWidth = 12; // Word index, address bits 13:2

  typedef logic [AddrWidth-1:0]        addr_t;
  typedef logic [DataWidth-1:0]        data_t;
  typedef logic [StrbWidth-1:0]        strb_t;
  typedef logic [$clog2(NumPorts)-1:0] port_idx_t;
  typedef logic [NumCores-1:0]         core_mask_t;
  typedef logic [15:0]                 ctrl_off_t; // Offset inside the control window

  typedef enum logic [1:0] {
    TgtCtrl,
    TgtL2,
    TgtBootrom,
    TgtExternal // Default route
  } target_e;

  // Address map
  localparam addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam addr_t CtrlEndAddr     = 32'h4000_FFFF;
  localparam addr_t L2BaseAddr      = 32'h8000_0000;
  localparam addr_t L2EndAddr       = 32'h801F_FFFF;
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam addr_t BootromEndAddr  = 32'hA000_FFFF;

  localparam addr_t TCDMBaseAddr = 32'h0000_0000;
  localparam addr_t TCDMSize     = 32'h0000_4000;

  // Control register offsets
  localparam ctrl_off_t CtrlWakeUpOff    = 16'h0000;
  localparam ctrl_off_t CtrlEocOff       = 16'h0004;
  localparam ctrl_off_t CtrlTcdmStartOff = 16'h0008;
  localparam ctrl_off_t CtrlTcdmEndOff   = 16'h000C;
  localparam ctrl_off_t CtrlNumCoresOff  = 16'h0010;

  // Boot image, indexed by address bits 4:2
  localparam int unsigned BootromWords = 8;
  localparam data_t BootromImage [BootromWords] = '{
    32'h0000_0297, 32'h0202_8293, 32'h3052_9073, 32'h1050_0073,
    32'hFFDF_F06F, 32'h0000_0013, 32'hCAFE_F00D, 32'h600D_C0DE
  };

endpackage : mempool_system_pkg
